//--- include/branch_cfg.svh
/*
  build-time parameters of the branch execution block
  BR_RAS_DEPTH must be a power of two, the stack pointer wraps
  BR_XLEN other than 32 is not supported by the RV32I decode
*/
`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// width of operands, pc and addresses
`define BR_XLEN 32

// return address stack entries
`define BR_RAS_DEPTH 8

`endif

//--- design/branch_pkg.sv
/*
  types shared by the branch execution block and its testbench
  widths come from branch_cfg.svh
*/
`default_nettype none

`include "branch_cfg.svh"

package branch_pkg;

    // operands and addresses
    typedef logic [`BR_XLEN-1:0] xlen_t;

    // raw instruction word, always 32 bits in RV32I
    typedef logic [31:0] instr_t;

    // funct3 of a conditional branch
    typedef logic [2:0] fn3_t;

    // tag travelling with the writeback
    typedef logic [3:0] instr_id_t;

    // index into the return address stack
    typedef logic [$clog2(`BR_RAS_DEPTH)-1:0] ras_ptr_t;

    // decoded instruction kind, BR_NONE is never accepted
    typedef enum logic [1:0] {
        BR_COND,
        BR_JAL,
        BR_JALR,
        BR_NONE
    } br_kind_t;

    // writeback hold FSM
    typedef enum logic {
        WB_IDLE,
        WB_HOLD
    } wb_state_t;

endpackage

`default_nettype wire

//--- design/branch_ifs.sv
/*
  internal buses of the branch block
  br_req_if carries the accepted request, valid only while fire is high
  ras_if push and pop are single-cycle pulses, pop is applied before push
*/
`default_nettype none

interface br_req_if import branch_pkg::*; ();

    // request accepted this cycle
    logic     fire;
    br_kind_t kind;
    instr_t   instr;
    xlen_t    pc;
    xlen_t    rs1;
    xlen_t    rs2;

    modport ctrl (
        output fire, kind, instr, pc, rs1, rs2
    );

    // datapath side only samples
    modport dp (
        input fire, kind, instr, pc, rs1, rs2
    );

endinterface

interface ras_if import branch_pkg::*; ();

    logic  push;
    logic  pop;
    xlen_t push_addr;
    // current top entry and occupancy flag
    xlen_t top_addr;
    logic  empty;

    modport ctrl (
        output push, pop, push_addr,
        input  top_addr, empty
    );

    modport stack (
        input  push, pop, push_addr,
        output top_addr, empty
    );

endinterface

`default_nettype wire

//--- design/branch_control.sv
/*
  issue gating, decode and execute-stage control of the branch block
  only one writeback can be pending, issue stalls until it is accepted
  call and return detection follows the x1/x5 link register convention
*/
`default_nettype none

module branch_control import branch_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue,
    input  instr_t    instr,
    input  xlen_t     pc,
    input  xlen_t     rs1,
    input  xlen_t     rs2,
    input  instr_id_t id,
    input  logic      cond_met,
    input  logic      wb_accepted,
    output logic      ready,
    output logic      ex_valid,
    output logic      branch_taken,
    output logic      is_return_ex,
    output logic      wb_done,
    output xlen_t     wb_rd,
    output instr_id_t wb_id,
    br_req_if.ctrl    req,
    ras_if.ctrl       ras
);

    br_kind_t  kind;
    wb_state_t wb_state;
    logic      fire;
    logic      is_jump;
    logic      uses_rd;
    logic      rd_link;
    logic      rs1_link;
    logic      is_call;
    logic      is_return;

    // opcode decode
    always_comb begin
        case (instr[6:0])
            7'b1100011: kind = BR_COND;
            7'b1101111: kind = BR_JAL;
            7'b1100111: kind = BR_JALR;
            default:    kind = BR_NONE;
        endcase
    end

    assign is_jump = (kind == BR_JAL) || (kind == BR_JALR);
    // rd field holds immediate bits for branches
    assign uses_rd = is_jump && (instr[11:7] != 5'd0);

    // x1 or x5 as link register
    assign rd_link  = (instr[11:7] == 5'd1) || (instr[11:7] == 5'd5);
    assign rs1_link = (instr[19:15] == 5'd1) || (instr[19:15] == 5'd5);

    assign is_call = is_jump && rd_link;
    // jalr with two different link regs is a pop then a push
    assign is_return = (kind == BR_JALR) && rs1_link &&
                       (!rd_link || (instr[19:15] != instr[11:7]));

    // stalled only while a held result is not taken this cycle
    assign ready = (wb_state == WB_IDLE) || wb_accepted;
    assign fire  = issue && ready && (kind != BR_NONE);

    assign req.fire  = fire;
    assign req.kind  = kind;
    assign req.instr = instr;
    assign req.pc    = pc;
    assign req.rs1   = rs1;
    assign req.rs2   = rs2;

    // execute stage flags and stack pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_valid     <= 1'b0;
            branch_taken <= 1'b0;
            is_return_ex <= 1'b0;
            ras.push     <= 1'b0;
            ras.pop      <= 1'b0;
        end else begin
            ex_valid <= fire;
            ras.push <= fire && is_call;
            ras.pop  <= fire && is_return;
            if (fire) begin
                // fn3 bit 0 inverts bne, bge, bgeu
                branch_taken <= is_jump || (cond_met ^ instr[12]);
                is_return_ex <= is_return;
            end
        end
    end

    // link value, also the address pushed on a call
    always_ff @(posedge clk) begin
        if (fire && uses_rd) begin
            wb_rd <= pc + xlen_t'(4);
            wb_id <= id;
        end
    end

    assign ras.push_addr = wb_rd;

    // writeback hold
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_state <= WB_IDLE;
        end else if (fire && uses_rd) begin
            wb_state <= WB_HOLD;
        end else if (wb_accepted) begin
            wb_state <= WB_IDLE;
        end
    end

    assign wb_done = (wb_state == WB_HOLD);

    // held result is never dropped before the writeback side takes it
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_done && !wb_accepted) |=> wb_done);

    // an empty stack never sees a combined pop and push
    a_ras_underflow: assert property (@(posedge clk) disable iff (rst)
        (ras.pop && ras.empty) |-> !ras.push);

endmodule

`default_nettype wire

//--- design/branch_comparator.sv
/*
  condition compare for conditional branches, purely combinational
  gives eq for fn3 00x and lt for 1xx, before the fn3[0] inversion
  fn3 01x is not a branch and yields the equality result
*/
`default_nettype none

`include "branch_cfg.svh"

module branch_comparator import branch_pkg::*; (
    br_req_if.dp req,
    output logic cond_met
);

    fn3_t                fn3;
    logic                use_signed;
    logic [`BR_XLEN:0]   a_ext;
    logic [`BR_XLEN:0]   b_ext;
    logic [`BR_XLEN:0]   diff;
    logic                less_than;
    logic                equal;

    assign fn3 = req.instr[14:12];

    // blt/bge signed, bltu/bgeu unsigned
    assign use_signed = !fn3[1];

    // one extra bit so a single subtract covers both cases
    assign a_ext = {use_signed && req.rs1[`BR_XLEN-1], req.rs1};
    assign b_ext = {use_signed && req.rs2[`BR_XLEN-1], req.rs2};

    assign diff      = a_ext - b_ext;
    assign less_than = diff[`BR_XLEN];
    assign equal     = (req.rs1 == req.rs2);

    assign cond_met = fn3[2] ? less_than : equal;

endmodule

`default_nettype wire

//--- design/branch_target_calc.sv
/*
  target and fall-through address generation
  outputs load only on an accepted request and hold otherwise
  misaligned targets are not flagged, bit 0 is simply cleared
*/
`default_nettype none

`include "branch_cfg.svh"

module branch_target_calc import branch_pkg::*; (
    input  logic  clk,
    br_req_if.dp  req,
    output xlen_t jump_pc,
    output xlen_t njump_pc,
    output xlen_t ex_pc
);

    logic [11:0] b_imm;
    logic [19:0] j_imm;
    logic [11:0] i_imm;
    xlen_t       offset;
    xlen_t       base;
    xlen_t       target;
    xlen_t       pc_plus_4;

    // B and J immediates leave out bit 0, always zero
    assign b_imm = {req.instr[31], req.instr[7], req.instr[30:25], req.instr[11:8]};
    assign j_imm = {req.instr[31], req.instr[19:12], req.instr[20], req.instr[30:21]};
    assign i_imm = req.instr[31:20];

    // sign extend by kind
    always_comb begin
        case (req.kind)
            BR_JAL:  offset = xlen_t'(signed'({j_imm, 1'b0}));
            BR_JALR: offset = xlen_t'(signed'(i_imm));
            default: offset = xlen_t'(signed'({b_imm, 1'b0}));
        endcase
    end

    // jalr is register relative
    assign base = (req.kind == BR_JALR) ? req.rs1 : req.pc;

    assign target    = base + offset;
    assign pc_plus_4 = req.pc + xlen_t'(4);

    always_ff @(posedge clk) begin
        if (req.fire) begin
            jump_pc  <= {target[`BR_XLEN-1:1], 1'b0};
            njump_pc <= pc_plus_4;
            ex_pc    <= req.pc;
        end
    end

    // pc relative targets need no bit 0 fixup, so bit 1 is pc[1] ^ imm[1]
    a_pcrel_align: assert property (@(posedge clk)
        (req.fire && (req.kind == BR_COND || req.kind == BR_JAL))
        |=> (jump_pc[1] == $past(req.pc[1] ^ offset[1])));

endmodule

`default_nettype wire

//--- design/return_addr_stack.sv
/*
  circular return address stack
  push on a full stack overwrites the oldest entry
  pop on an empty stack is dropped, pop is applied before push
*/
`default_nettype none

`include "branch_cfg.svh"

module return_addr_stack import branch_pkg::*; (
    input  logic clk,
    input  logic rst,
    ras_if.stack ras
);

    localparam int DEPTH = `BR_RAS_DEPTH;

    typedef logic [$clog2(DEPTH):0] cnt_t;

    xlen_t    entries [DEPTH];
    ras_ptr_t ptr;
    ras_ptr_t ptr_popped;
    ras_ptr_t ptr_next;
    cnt_t     count;
    cnt_t     count_popped;
    cnt_t     count_next;
    logic     pop_ok;

    assign pop_ok = ras.pop && (count != '0);

    // pop first
    assign ptr_popped   = pop_ok ? ptr - 1'b1 : ptr;
    assign count_popped = pop_ok ? count - 1'b1 : count;

    // then push, saturating the count when wrapping over old entries
    assign ptr_next = ras.push ? ptr_popped + 1'b1 : ptr_popped;
    always_comb begin
        if (ras.push && (count_popped != cnt_t'(DEPTH)))
            count_next = count_popped + 1'b1;
        else
            count_next = count_popped;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr   <= '0;
            count <= '0;
        end else begin
            ptr   <= ptr_next;
            count <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ras.push)
            entries[ptr_next] <= ras.push_addr;
    end

    assign ras.top_addr = entries[ptr];
    assign ras.empty    = (count == '0);

endmodule

`default_nettype wire

//--- design/branch_exec_top.sv
/*
  branch execution block, top level
  resolve and writeback appear one cycle after an accepted issue
  ras_top follows a call or return two cycles after issue
*/
`default_nettype none

module branch_exec_top import branch_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      issue,
    input  instr_t    instr,
    input  xlen_t     pc,
    input  xlen_t     rs1,
    input  xlen_t     rs2,
    input  instr_id_t id,
    input  logic      wb_accepted,
    output logic      ready,
    output logic      ex_valid,
    output logic      branch_taken,
    output xlen_t     jump_pc,
    output xlen_t     njump_pc,
    output xlen_t     ex_pc,
    output logic      is_return_ex,
    output logic      wb_done,
    output xlen_t     wb_rd,
    output instr_id_t wb_id,
    output xlen_t     ras_top,
    output logic      ras_empty
);

    logic cond_met;

    br_req_if req_bus ();
    ras_if    ras_bus ();

    branch_control u_control (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .instr        (instr),
        .pc           (pc),
        .rs1          (rs1),
        .rs2          (rs2),
        .id           (id),
        .cond_met     (cond_met),
        .wb_accepted  (wb_accepted),
        .ready        (ready),
        .ex_valid     (ex_valid),
        .branch_taken (branch_taken),
        .is_return_ex (is_return_ex),
        .wb_done      (wb_done),
        .wb_rd        (wb_rd),
        .wb_id        (wb_id),
        .req          (req_bus.ctrl),
        .ras          (ras_bus.ctrl)
    );

    branch_comparator u_comparator (
        .req      (req_bus.dp),
        .cond_met (cond_met)
    );

    branch_target_calc u_target (
        .clk      (clk),
        .req      (req_bus.dp),
        .jump_pc  (jump_pc),
        .njump_pc (njump_pc),
        .ex_pc    (ex_pc)
    );

    return_addr_stack u_ras (
        .clk (clk),
        .rst (rst),
        .ras (ras_bus.stack)
    );

    // stack state straight out
    assign ras_top   = ras_bus.top_addr;
    assign ras_empty = ras_bus.empty;

endmodule

`default_nettype wire

//--- sim/branch_exec_tb.sv
/*
  testbench for branch_exec_top, vectors from sim/branch_exec_testdata.txt
  must run from the project root so the data file path resolves
  ras_top is compared only where the stack is expected to hold entries
*/
`default_nettype none

module branch_exec_tb import branch_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic      clk;
    logic      rst;
    logic      issue;
    instr_t    instr;
    xlen_t     pc;
    xlen_t     rs1;
    xlen_t     rs2;
    instr_id_t id;
    logic      wb_accepted;
    logic      ready;
    logic      ex_valid;
    logic      branch_taken;
    xlen_t     jump_pc;
    xlen_t     njump_pc;
    xlen_t     ex_pc;
    logic      is_return_ex;
    logic      wb_done;
    xlen_t     wb_rd;
    instr_id_t wb_id;
    xlen_t     ras_top;
    logic      ras_empty;

    // vectors as read from the file
    instr_t    v_instr [$];
    xlen_t     v_pc [$];
    xlen_t     v_rs1 [$];
    xlen_t     v_rs2 [$];
    instr_id_t v_id [$];
    int        v_delay [$];
    logic      v_taken [$];
    xlen_t     v_jump [$];
    logic      v_wb [$];
    xlen_t     v_top [$];
    logic      v_empty [$];
    int        vec_total;
    logic      loaded;
    integer    seed;

    // model of the writeback the DUT should be holding
    logic      pend;
    int        hold_left;
    xlen_t     held_rd;
    instr_id_t held_id;

    branch_exec_top UUT (
        .clk          (clk),
        .rst          (rst),
        .issue        (issue),
        .instr        (instr),
        .pc           (pc),
        .rs1          (rs1),
        .rs2          (rs2),
        .id           (id),
        .wb_accepted  (wb_accepted),
        .ready        (ready),
        .ex_valid     (ex_valid),
        .branch_taken (branch_taken),
        .jump_pc      (jump_pc),
        .njump_pc     (njump_pc),
        .ex_pc        (ex_pc),
        .is_return_ex (is_return_ex),
        .wb_done      (wb_done),
        .wb_rd        (wb_rd),
        .wb_id        (wb_id),
        .ras_top      (ras_top),
        .ras_empty    (ras_empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("[FAIL] at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_addr(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp)
            report_mismatch(name, got, exp);
    endtask

    task automatic check_id(input string name, input instr_id_t got, input instr_id_t exp);
        if (got !== exp)
            report_mismatch(name, 32'(got), 32'(exp));
    endtask

    // jalr through x1 or x5 that does not link back into the same register
    function automatic logic expect_return(input instr_t ins);
        logic [4:0] rd_f;
        logic [4:0] rs1_f;
        rd_f  = ins[11:7];
        rs1_f = ins[19:15];
        return (ins[6:0] == 7'b1100111) && ((rs1_f == 5'd1) || (rs1_f == 5'd5)) &&
               (rd_f != rs1_f);
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] t_instr;
        logic [31:0] t_pc;
        logic [31:0] t_rs1;
        logic [31:0] t_rs2;
        logic [31:0] t_id;
        int          t_delay;
        logic [31:0] t_taken;
        logic [31:0] t_jump;
        logic [31:0] t_wb;
        logic [31:0] t_top;
        logic [31:0] t_empty;
        fd = $fopen("sim/branch_exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open the test data file sim/branch_exec_testdata.txt");
            $display("Test FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // comment and blank lines give fewer than 11 fields
            if ((n > 0) && (line[0] != "#")) begin
                n = $sscanf(line, "%h %h %h %h %h %d %h %h %h %h %h",
                            t_instr, t_pc, t_rs1, t_rs2, t_id, t_delay,
                            t_taken, t_jump, t_wb, t_top, t_empty);
                if (n == 11) begin
                    v_instr.push_back(t_instr);
                    v_pc.push_back(t_pc);
                    v_rs1.push_back(t_rs1);
                    v_rs2.push_back(t_rs2);
                    v_id.push_back(t_id[3:0]);
                    v_delay.push_back(t_delay);
                    v_taken.push_back(t_taken[0]);
                    v_jump.push_back(t_jump);
                    v_wb.push_back(t_wb[0]);
                    v_top.push_back(t_top);
                    v_empty.push_back(t_empty[0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // a held writeback must not move
    task automatic check_held();
        if (pend) begin
            check_bit("wb_done", wb_done, 1'b1);
            check_addr("wb_rd", wb_rd, held_rd);
            check_id("wb_id", wb_id, held_id);
        end
    endtask

    // every task starts and ends at a falling edge
    // the hold delay only counts down while the next issue is stalled
    task automatic idle_cycle();
        issue       = 1'b0;
        wb_accepted = 1'b0;
        #1;
        check_bit("ready", ready, !pend);
        check_held();
        @(negedge clk);
        check_bit("ex_valid", ex_valid, 1'b0);
    endtask

    task automatic run_vector(input int k);
        logic  accepted;
        xlen_t link;
        accepted = 1'b0;
        link     = v_pc[k] + 32'd4;
        while (!accepted) begin
            issue = 1'b1;
            instr = v_instr[k];
            pc    = v_pc[k];
            rs1   = v_rs1[k];
            rs2   = v_rs2[k];
            id    = v_id[k];
            // release the held writeback once its delay has run out
            wb_accepted = pend && (hold_left == 0);
            #1;
            check_bit("ready", ready, !pend || wb_accepted);
            check_held();
            accepted = !pend || wb_accepted;
            @(negedge clk);
            if (!accepted) begin
                // stalled issue, nothing may resolve
                check_bit("ex_valid", ex_valid, 1'b0);
                hold_left--;
            end
        end
        // resolve cycle N+1
        check_bit("ex_valid", ex_valid, 1'b1);
        check_bit("branch_taken", branch_taken, v_taken[k]);
        check_addr("jump_pc", jump_pc, v_jump[k]);
        check_addr("njump_pc", njump_pc, link);
        check_addr("ex_pc", ex_pc, v_pc[k]);
        check_bit("is_return_ex", is_return_ex, expect_return(v_instr[k]));
        check_bit("wb_done", wb_done, v_wb[k]);
        pend      = v_wb[k];
        hold_left = v_delay[k];
        held_rd   = link;
        held_id   = v_id[k];
        check_held();
        issue       = 1'b0;
        wb_accepted = 1'b0;
        @(negedge clk);
        // stack moved at the edge after the pulse
        check_bit("ex_valid", ex_valid, 1'b0);
        check_bit("ras_empty", ras_empty, v_empty[k]);
        if (!v_empty[k])
            check_addr("ras_top", ras_top, v_top[k]);
    endtask

    initial begin
        int idle;
        seed        = 32'he73b280b;
        loaded      = 1'b0;
        rst         = 1'b1;
        issue       = 1'b0;
        instr       = '0;
        pc          = '0;
        rs1         = '0;
        rs2         = '0;
        id          = '0;
        wb_accepted = 1'b0;
        pend        = 1'b0;
        hold_left   = 0;
        held_rd     = '0;
        held_id     = '0;
        load_vectors();
        vec_total = v_instr.size();
        loaded    = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        // state straight out of reset
        check_bit("ready", ready, 1'b1);
        check_bit("ex_valid", ex_valid, 1'b0);
        check_bit("wb_done", wb_done, 1'b0);
        check_bit("ras_empty", ras_empty, 1'b1);
        @(negedge clk);
        for (int k = 0; k < vec_total; k++) begin
            run_vector(k);
            idle = $unsigned($random(seed)) % 4;
            repeat (idle) idle_cycle();
        end
        // release a writeback still held at the end
        if (pend) begin
            wb_accepted = 1'b1;
            @(negedge clk);
            wb_accepted = 1'b0;
            check_bit("wb_done", wb_done, 1'b0);
        end
        if (vec_total == 0) begin
            $display("no test vectors were read from the data file");
            $display("Test FAILED");
            $fatal(1);
        end else begin
            $display("Test OK");
            $finish;
        end
    end

    // budget of 20 cycles per vector covers stalls and idle gaps
    initial begin
        wait (loaded);
        repeat (vec_total * 20 + 100) @(posedge clk);
        $display("timeout: writeback or issue never completed");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- branch_exec.f
+incdir+include
design/branch_pkg.sv
design/branch_ifs.sv
design/branch_control.sv
design/branch_comparator.sv
design/branch_target_calc.sv
design/return_addr_stack.sv
design/branch_exec_top.sv
sim/branch_exec_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the branch execution testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module branch_exec_tb -f branch_exec.f -o branch_exec_sim

status=0
./obj_dir/branch_exec_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- sim/branch_exec_testdata.txt
# instr pc rs1 rs2 id delay | expected: taken jump_pc rd_written ras_top ras_empty
# hex fields except delay (decimal cycles wb_accepted stays low), ras_top unused when empty
00B50863 00001000 00000005 00000005 1 0 1 00001010 0 00000000 1
FEB51CE3 00002000 80000000 7FFFFFFF 2 0 1 00001FF8 0 00000000 1
00B54863 00002100 80000000 7FFFFFFF 3 0 1 00002110 0 00000000 1
FEB54CE3 00002200 7FFFFFFF 80000000 4 0 0 000021F8 0 00000000 1
00B55863 00002300 FFFFFFFF 00000000 5 0 0 00002310 0 00000000 1
00B56863 00002400 00000000 FFFFFFFF 6 0 1 00002410 0 00000000 1
00B56863 00002404 80000000 7FFFFFFF 7 0 0 00002414 0 00000000 1
FEB57CE3 00002500 FFFFFFFF 00000001 8 0 1 000024F8 0 00000000 1
1000006F 00003000 00000000 00000000 9 0 1 00003100 0 00000000 1
00350067 00003100 00004000 00000000 A 0 1 00004002 0 00000000 1
FFF50367 00003200 00005000 00000000 B 3 1 00004FFE 1 00000000 1
00008067 00003300 00006000 00000000 C 0 1 00006000 0 00000000 1
100000EF 00004000 00000000 00000000 D 0 1 00004100 1 00004004 0
000500E7 00004100 00008000 00000000 E 2 1 00008000 1 00004104 0
FF1FF2EF 00008000 00000000 00000000 F 1 1 00007FF0 1 00008004 0
000280E7 00007FF0 00008004 00000000 0 0 1 00008004 1 00007FF4 0
00008067 00008004 00007FF4 00000000 1 0 1 00007FF4 0 00004104 0
00028067 00007FF4 00004104 00000000 2 0 1 00004104 0 00004004 0
00008067 00004104 00004004 00000000 3 0 1 00004004 0 00000000 1
00008067 00004004 00001000 00000000 4 0 1 00001000 0 00000000 1
